// ==== verilog/spi_ctrl_pkg.sv ====
package spi_ctrl_pkg;

    // Hard SPI block register map
    localparam logic [7:0] addr_txdr = 8'h59;  // Transmit data
    localparam logic [7:0] addr_sr   = 8'h5A;  // Status
    localparam logic [7:0] addr_rxdr = 8'h5B;  // Receive data

    // Status register flags
    localparam int sr_rx_rdy_bit = 3;
    localparam int sr_tx_rdy_bit = 4;

    // Command bytes as sent by the host
    localparam logic [7:0] code_set_out    = 8'h01;
    localparam logic [7:0] code_read_out   = 8'h02;
    localparam logic [7:0] code_sel_spi    = 8'h03;
    localparam logic [7:0] code_meas_state = 8'h04;

    // Decoded command, held through the parameter phase
    typedef enum logic [3:0] {
        SET_OUT    = 4'h0,
        READ_OUT   = 4'h1,
        SEL_SPI    = 4'h2,
        MEAS_STATE = 4'h3,
        INVALID    = 4'hF
    } cmd_e;

    typedef enum logic [3:0] {
        IDLE, RXDR_RD, TXDR_WR, CMD_POLL, CMD_LD, CMD_DEC,
        TXDR_WR1, PARAM_POLL, PARAM_LD, REPLY_WR, REPLY_POLL
    } seq_state_e;

    // SET_OUT group nibble
    localparam logic [3:0] grp_input = 4'h1;
    localparam logic [3:0] grp_mu    = 4'h2;
    localparam logic [3:0] grp_avk   = 4'h3;
    localparam logic [3:0] grp_fil1  = 4'h4;
    localparam logic [3:0] grp_fil2  = 4'h5;

    localparam logic [7:0] reply_ack  = 8'hFF;
    localparam logic [7:0] reply_nack = 8'h00;

    // Power-up state of the front end
    localparam logic [3:0] input_sel_rst = 4'b1111;  // No input selected
    localparam logic [2:0] mu_sel_rst    = 3'b110;
    localparam logic [3:0] avk_sel_rst   = 4'b1111;
    localparam logic       fil1_rst      = 1'b0;
    localparam logic       fil2_rst      = 1'b1;
    localparam logic [2:0] cs_rst        = 3'b111;   // All downstream chips deselected

    localparam logic [3:0] meas_fixed_bits = 4'b0001;  // Upper nibble of the state byte

endpackage

// ==== verilog/csn_sync.sv ====
`timescale 1ns/10ps

module csn_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic spi_csn,
    input  logic seq_idle,
    input  logic seq_idle_or_rxdr,
    output logic csn_s,
    output logic start_pending,
    output logic spi_done
);

    logic csn_m;     // First synchronizer stage
    logic csn_d;     // Delayed copy for edge detect
    logic csn_fall;
    logic csn_rise;
    logic done_hold;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            csn_m <= 1'b1;  // Deselected
            csn_s <= 1'b1;
            csn_d <= 1'b1;
        end else begin
            csn_m <= spi_csn;
            csn_s <= csn_m;
            csn_d <= csn_s;
        end
    end

    assign csn_fall = csn_d & ~csn_s;  // Host starts a transfer
    assign csn_rise = ~csn_d & csn_s;  // Host ends it

    // Start request stays up until the sequencer has moved on to the RXDR read
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            start_pending <= 1'b0;
        else if (csn_fall)
            start_pending <= 1'b1;
        else if ((seq_idle_or_rxdr && !seq_idle) || csn_rise)
            start_pending <= 1'b0;
    end

    // End of transfer is remembered until the sequencer is back in IDLE
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            done_hold <= 1'b0;
        else if (csn_rise)
            done_hold <= 1'b1;
        else if (seq_idle)
            done_hold <= 1'b0;
    end

    assign spi_done = csn_rise | done_hold;

endmodule

// ==== verilog/efb_sequencer.sv ====
`timescale 1ns/10ps

module efb_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_pending,
    input  logic               spi_done,
    input  logic               xfer_req,
    input  logic               xfer_done,
    input  logic [7:0]         rd_data,
    input  logic [7:0]         reply,
    output logic               rd_en,
    output logic               wr_en,
    output logic [7:0]         address,
    output logic [7:0]         wr_data,
    output logic               seq_idle,
    output logic               seq_idle_or_rxdr,
    output logic               apply,
    output spi_ctrl_pkg::cmd_e cmd,
    output logic [7:0]         param
);
    import spi_ctrl_pkg::*;

    seq_state_e state;
    logic       rx_rdy;  // Status flags, only meaningful on a completed SR read
    logic       tx_rdy;
    logic       reload;  // TXDR rewrite in flight, its completion carries no status

    // Wire code to internal command
    function automatic cmd_e decode_cmd(input logic [7:0] code);
        case (code)
            code_set_out:    decode_cmd = SET_OUT;
            code_read_out:   decode_cmd = READ_OUT;
            code_sel_spi:    decode_cmd = SEL_SPI;
            code_meas_state: decode_cmd = MEAS_STATE;
            default:         decode_cmd = INVALID;
        endcase
    endfunction

    assign rx_rdy = rd_data[sr_rx_rdy_bit];
    assign tx_rdy = rd_data[sr_tx_rdy_bit];

    assign seq_idle         = (state == IDLE);
    assign seq_idle_or_rxdr = (state == IDLE) || (state == RXDR_RD);

    // Parameter byte goes straight to the select registers with its completion
    assign apply = (state == PARAM_LD) && xfer_done;
    assign param = rd_data;

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state   <= IDLE;
            rd_en   <= 1'b0;
            wr_en   <= 1'b0;
            address <= addr_txdr;
            wr_data <= 8'h00;
            cmd     <= INVALID;
            reload  <= 1'b0;
        end else begin
            rd_en   <= 1'b0;       // Strobes last one cycle
            wr_en   <= 1'b0;
            address <= addr_txdr;  // Resting address

            case (state)
                IDLE: begin
                    if (start_pending && xfer_req) begin
                        state   <= RXDR_RD;
                        rd_en   <= 1'b1;       // Flush whatever sits in RXDR
                        address <= addr_rxdr;
                    end
                end
                RXDR_RD: begin
                    if (xfer_done) begin
                        state   <= TXDR_WR;
                        wr_en   <= 1'b1;
                        wr_data <= 8'h00;     // Dummy byte shifted out with the command
                    end
                end
                TXDR_WR: begin
                    if (xfer_done) begin
                        state   <= CMD_POLL;
                        rd_en   <= 1'b1;
                        address <= addr_sr;
                    end
                end
                CMD_POLL, PARAM_POLL, REPLY_POLL: begin
                    if (xfer_done) begin
                        if (reload) begin
                            reload  <= 1'b0;
                            rd_en   <= 1'b1;    // Back to polling status
                            address <= addr_sr;
                        end else if (rx_rdy) begin
                            if (state == REPLY_POLL) begin
                                state <= IDLE;  // Trailing byte ends the command
                            end else begin
                                rd_en   <= 1'b1;
                                address <= addr_rxdr;
                                if (state == CMD_POLL)
                                    state <= CMD_LD;
                                else
                                    state <= PARAM_LD;
                            end
                        end else if (spi_done) begin
                            state <= IDLE;      // Host gave up the transfer
                        end else if (tx_rdy) begin
                            wr_en  <= 1'b1;     // Reload TXDR with the same byte
                            reload <= 1'b1;
                        end else begin
                            rd_en   <= 1'b1;    // Keep polling status
                            address <= addr_sr;
                        end
                    end
                end
                CMD_LD: begin
                    if (xfer_done) begin
                        state <= CMD_DEC;
                        cmd   <= decode_cmd(rd_data);
                    end
                end
                CMD_DEC: begin
                    // Single cycle, no bus access pending here
                    if (spi_done || cmd == INVALID) begin
                        state <= IDLE;
                    end else begin
                        state   <= TXDR_WR1;
                        wr_en   <= 1'b1;
                        wr_data <= 8'h00;     // Second dummy, goes out with the parameter
                    end
                end
                TXDR_WR1: begin
                    if (xfer_done) begin
                        state   <= PARAM_POLL;
                        rd_en   <= 1'b1;
                        address <= addr_sr;
                    end
                end
                PARAM_LD: begin
                    if (xfer_done) begin
                        state   <= REPLY_WR;
                        wr_en   <= 1'b1;
                        wr_data <= reply;     // Computed this cycle from param
                    end
                end
                REPLY_WR: begin
                    if (xfer_done) begin
                        state   <= REPLY_POLL;
                        rd_en   <= 1'b1;
                        address <= addr_sr;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/select_regs.sv ====
`timescale 1ns/10ps

module select_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               apply,
    input  spi_ctrl_pkg::cmd_e cmd,
    input  logic [7:0]         param,
    input  logic [3:0]         fifo_level,
    input  logic               csn_s,
    output logic [7:0]         reply,
    output logic [3:0]         input_sel,
    output logic [2:0]         mu_sel,
    output logic [3:0]         avk_sel,
    output logic               fil1_sel,
    output logic               fil2_sel,
    output logic [2:0]         cs_out
);
    import spi_ctrl_pkg::*;

    logic [3:0] grp;
    logic [3:0] val;
    logic       legal;      // Group and value accepted
    logic [3:0] input_nxt;
    logic [2:0] mu_nxt;
    logic [3:0] avk_nxt;
    logic       fil1_nxt;
    logic       fil2_nxt;
    logic [2:0] cs_nxt;
    logic [2:0] cs_held;

    // 1..4 select one line low, anything else releases all
    function automatic logic [3:0] one_cold4(input logic [3:0] v);
        case (v)
            4'h1:    one_cold4 = 4'b1110;
            4'h2:    one_cold4 = 4'b1101;
            4'h3:    one_cold4 = 4'b1011;
            4'h4:    one_cold4 = 4'b0111;
            default: one_cold4 = 4'b1111;
        endcase
    endfunction

    function automatic logic [2:0] one_cold3(input logic [3:0] v);
        case (v)
            4'h1:    one_cold3 = 3'b110;
            4'h2:    one_cold3 = 3'b101;
            4'h3:    one_cold3 = 3'b011;
            default: one_cold3 = 3'b111;
        endcase
    endfunction

    assign grp = param[7:4];
    assign val = param[3:0];  // Also the READ_OUT index and SEL_SPI value

    always_comb begin
        legal     = 1'b0;
        input_nxt = input_sel;  // Hold unless a legal write below
        mu_nxt    = mu_sel;
        avk_nxt   = avk_sel;
        fil1_nxt  = fil1_sel;
        fil2_nxt  = fil2_sel;
        cs_nxt    = cs_held;
        reply     = reply_nack;
        case (cmd)
            SET_OUT: begin
                case (grp)
                    grp_input: begin
                        legal     = val inside {[4'h1:4'h4], 4'hF};
                        input_nxt = legal ? one_cold4(val) : input_sel;
                    end
                    grp_mu: begin
                        legal  = val inside {[4'h1:4'h3]};  // No release code for mu
                        mu_nxt = legal ? one_cold3(val) : mu_sel;
                    end
                    grp_avk: begin
                        legal   = val inside {[4'h1:4'h4], 4'hF};
                        avk_nxt = legal ? one_cold4(val) : avk_sel;
                    end
                    grp_fil1: begin
                        legal    = (val == 4'h0) || (val == 4'hF);
                        fil1_nxt = legal ? (val == 4'h0) : fil1_sel;  // 0 engages
                    end
                    grp_fil2: begin
                        legal    = (val == 4'h0) || (val == 4'hF);
                        fil2_nxt = legal ? (val == 4'h0) : fil2_sel;
                    end
                    default: legal = 1'b0;
                endcase
                reply = legal ? reply_ack : reply_nack;
            end
            SEL_SPI: begin
                legal  = val inside {[4'h1:4'h3], 4'hF};
                cs_nxt = legal ? one_cold3(val) : cs_held;
                reply  = legal ? reply_ack : reply_nack;
            end
            READ_OUT: begin
                case (val)
                    4'h1:    reply = {4'h0, input_sel};
                    4'h2:    reply = {5'h00, mu_sel};
                    4'h3:    reply = {4'h0, avk_sel};
                    4'h4:    reply = {7'h00, fil1_sel};
                    4'h5:    reply = {7'h00, fil2_sel};
                    default: reply = 8'hFF;  // Unknown index
                endcase
            end
            MEAS_STATE: reply = {meas_fixed_bits, fifo_level};
            default:    reply = reply_nack;
        endcase
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            input_sel <= input_sel_rst;
            mu_sel    <= mu_sel_rst;
            avk_sel   <= avk_sel_rst;
            fil1_sel  <= fil1_rst;
            fil2_sel  <= fil2_rst;
            cs_held   <= cs_rst;
        end else if (apply) begin
            input_sel <= input_nxt;
            mu_sel    <= mu_nxt;
            avk_sel   <= avk_nxt;
            fil1_sel  <= fil1_nxt;
            fil2_sel  <= fil2_nxt;
            cs_held   <= cs_nxt;
        end
    end

    // Downstream chips stay deselected while the host talks to us
    assign cs_out = csn_s ? cs_held : 3'b111;

endmodule

// ==== verilog/spi_ctrl_top.sv ====
`timescale 1ns/10ps

module spi_ctrl_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_csn,
    input  logic [7:0] rd_data,    // Register bus from the hard SPI block
    input  logic       xfer_req,
    input  logic       xfer_done,
    input  logic [3:0] fifo_level,
    output logic       rd_en,
    output logic       wr_en,
    output logic [7:0] address,
    output logic [7:0] wr_data,
    output logic [3:0] input_sel,  // Front-end selects
    output logic [2:0] mu_sel,
    output logic [3:0] avk_sel,
    output logic       fil1_sel,
    output logic       fil2_sel,
    output logic [2:0] cs_out
);
    import spi_ctrl_pkg::*;

    logic       csn_s;
    logic       start_pending;
    logic       spi_done;
    logic       seq_idle;
    logic       seq_idle_or_rxdr;
    logic       apply;
    cmd_e       cmd;
    logic [7:0] param;
    logic [7:0] reply;

    csn_sync i_csn_sync (
        .clk(clk), .rst_n(rst_n), .spi_csn(spi_csn),
        .seq_idle(seq_idle), .seq_idle_or_rxdr(seq_idle_or_rxdr),
        .csn_s(csn_s), .start_pending(start_pending), .spi_done(spi_done)
    );

    efb_sequencer i_seq (
        .clk(clk), .rst_n(rst_n), .start_pending(start_pending), .spi_done(spi_done),
        .xfer_req(xfer_req), .xfer_done(xfer_done), .rd_data(rd_data), .reply(reply),
        .rd_en(rd_en), .wr_en(wr_en), .address(address), .wr_data(wr_data),
        .seq_idle(seq_idle), .seq_idle_or_rxdr(seq_idle_or_rxdr),
        .apply(apply), .cmd(cmd), .param(param)
    );

    select_regs i_sel (
        .clk(clk), .rst_n(rst_n), .apply(apply), .cmd(cmd), .param(param),
        .fifo_level(fifo_level), .csn_s(csn_s), .reply(reply),
        .input_sel(input_sel), .mu_sel(mu_sel), .avk_sel(avk_sel),
        .fil1_sel(fil1_sel), .fil2_sel(fil2_sel), .cs_out(cs_out)
    );

endmodule

// ==== tb/spi_ctrl_props.sv ====
`timescale 1ns/10ps

module spi_ctrl_props (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  logic                     wr_en,
    input  logic                     xfer_done,
    input  logic                     apply,
    input  spi_ctrl_pkg::seq_state_e state
);
    import spi_ctrl_pkg::*;

    logic busy;  // Access issued, completion not seen yet

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n)
            busy <= 1'b0;
        else if (rd_en || wr_en)
            busy <= 1'b1;
        else if (xfer_done)
            busy <= 1'b0;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (rst_n) !(rd_en && wr_en))
        else $error("rd_en and wr_en are high in the same cycle");

    // Bus has no queue, so nothing new goes out until the last access is done
    a_wait_done: assert property (@(posedge clk) disable iff (rst_n) busy |-> !(rd_en || wr_en))
        else $error("new bus strobe issued before xfer_done");

    // Only the PARAM_LD completion leads into the reply write
    a_apply_state: assert property (@(posedge clk) disable iff (rst_n)
                                    apply |=> wr_en && state == REPLY_WR)
        else $error("apply raised outside PARAM_LD or without a reply write");

endmodule

bind efb_sequencer spi_ctrl_props i_props (
    .clk(clk), .rst_n(rst_n), .rd_en(rd_en), .wr_en(wr_en),
    .xfer_done(xfer_done), .apply(apply), .state(state)
);

// ==== tb/efb_spi_model.sv ====
`timescale 1ns/10ps

module efb_spi_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rd_en,
    input  logic        wr_en,
    input  logic [7:0]  address,
    input  logic [7:0]  wr_data,
    input  logic        load,         // New host transfer, bytes below
    input  logic [23:0] host_bytes,   // Command, parameter, trailing byte
    output logic [7:0]  rd_data,
    output logic        xfer_done,
    output logic        xfer_req,
    output logic [7:0]  tx_log [64],  // TXDR writes of the current transfer
    output int          tx_count
);
    import spi_ctrl_pkg::*;

    logic [7:0] rx_q[$];  // Bytes the host still has to shift in
    logic       armed;    // TXDR loaded since the last RXDR pop
    logic       busy;
    logic       req_wr;
    logic [7:0] req_addr;
    logic [7:0] req_data;
    logic [7:0] status;
    int         wait_cnt;

    assign xfer_req = !busy;

    // Everything runs on the falling edge so the DUT sees stable inputs
    always @(negedge clk) begin
        xfer_done <= 1'b0;
        if (rst_n) begin
            busy     = 1'b0;
            armed    = 1'b0;
            wait_cnt = 0;
            rx_q.delete();
            rd_data  <= 8'h00;
            tx_count <= 0;
        end else if (load) begin
            rx_q.delete();
            rx_q.push_back(host_bytes[23:16]);
            rx_q.push_back(host_bytes[15:8]);
            rx_q.push_back(host_bytes[7:0]);
            armed    = 1'b0;
            tx_count <= 0;
        end else if (busy) begin
            if (wait_cnt > 1) begin
                wait_cnt = wait_cnt - 1;
            end else begin
                busy = 1'b0;
                xfer_done <= 1'b1;
                if (req_wr) begin
                    if (req_addr == addr_txdr) begin
                        if (tx_count < 64)
                            tx_log[tx_count] <= req_data;
                        tx_count <= tx_count + 1;
                        armed = 1'b1;  // Host clocks a byte in against it
                    end
                end else if (req_addr == addr_sr) begin
                    status = 8'h00;
                    status[sr_rx_rdy_bit] = armed && (rx_q.size() != 0) &&
                                            ($urandom_range(3, 0) != 0);
                    status[sr_tx_rdy_bit] = ($urandom_range(3, 0) == 0);
                    rd_data <= status;
                end else if (req_addr == addr_rxdr && armed && rx_q.size() != 0) begin
                    rd_data <= rx_q.pop_front();
                    armed = 1'b0;
                end else begin
                    rd_data <= 8'h00;  // Flush read of an empty RXDR
                end
            end
        end else if (rd_en || wr_en) begin
            busy     = 1'b1;
            wait_cnt = $urandom_range(3, 1);
            req_wr   = wr_en;
            req_addr = address;
            req_data = wr_data;
        end
    end

endmodule

// ==== tb/tb_spi_ctrl.sv ====
`timescale 1ns/10ps

module tb_spi_ctrl;
    import spi_ctrl_pkg::*;

    localparam int num_trans   = 200;
    localparam int cycle_limit = num_trans * 80;  // Worst case per transfer

    logic        clk;
    logic        rst_n;
    logic        spi_csn;
    logic [7:0]  rd_data;
    logic        xfer_req;
    logic        xfer_done;
    logic [3:0]  fifo_level;
    logic        rd_en;
    logic        wr_en;
    logic [7:0]  address;
    logic [7:0]  wr_data;
    logic [3:0]  input_sel;
    logic [2:0]  mu_sel;
    logic [3:0]  avk_sel;
    logic        fil1_sel;
    logic        fil2_sel;
    logic [2:0]  cs_out;
    logic        load;
    logic [23:0] host_bytes;
    logic [7:0]  tx_log [64];
    int          tx_count;
    int          cycles = 0;

    // Expected front-end state
    logic [3:0]  m_input;
    logic [2:0]  m_mu;
    logic [3:0]  m_avk;
    logic        m_fil1;
    logic        m_fil2;
    logic [2:0]  m_cs;

    spi_ctrl_top i_dut (
        .clk(clk), .rst_n(rst_n), .spi_csn(spi_csn), .rd_data(rd_data),
        .xfer_req(xfer_req), .xfer_done(xfer_done), .fifo_level(fifo_level),
        .rd_en(rd_en), .wr_en(wr_en), .address(address), .wr_data(wr_data),
        .input_sel(input_sel), .mu_sel(mu_sel), .avk_sel(avk_sel),
        .fil1_sel(fil1_sel), .fil2_sel(fil2_sel), .cs_out(cs_out)
    );

    efb_spi_model i_model (
        .clk(clk), .rst_n(rst_n), .rd_en(rd_en), .wr_en(wr_en), .address(address),
        .wr_data(wr_data), .load(load), .host_bytes(host_bytes), .rd_data(rd_data),
        .xfer_done(xfer_done), .xfer_req(xfer_req), .tx_log(tx_log), .tx_count(tx_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("test failed");
            $fatal(1, "Run did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            $display("test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            $display("test failed");
            $fatal(1, "%s", what);
        end
    endtask

    // Line v of n pulled low, F releases all
    function automatic logic [3:0] cold4(input logic [3:0] v);
        cold4 = (v == 4'hF) ? 4'hF : ~(4'h1 << (v - 4'h1));
    endfunction

    function automatic logic [2:0] cold3(input logic [3:0] v);
        cold3 = (v == 4'hF) ? 3'h7 : ~(3'h1 << (v - 4'h1));
    endfunction

    function automatic logic [3:0] pick_value();
        int r;
        r = $urandom_range(6, 0);
        pick_value = (r == 6) ? 4'hF : r[3:0];  // 0..5 or F
    endfunction

    // Reply of a command and its effect on the expected selects
    task automatic predict(input logic [7:0] c, input logic [7:0] p, input logic [3:0] f,
                           output logic has_reply, output logic [7:0] exp);
        logic [3:0] g;
        logic [3:0] v;
        logic       ok4;
        logic       ok3;
        logic       okf;
        g   = p[7:4];
        v   = p[3:0];
        ok4 = (v >= 4'h1 && v <= 4'h4) || v == 4'hF;
        ok3 = (v >= 4'h1 && v <= 4'h3) || v == 4'hF;
        okf = (v == 4'h0) || (v == 4'hF);
        has_reply = 1'b1;
        exp       = reply_nack;
        case (c)
            code_set_out: begin
                if (g == grp_input && ok4) begin
                    m_input = cold4(v);
                    exp     = reply_ack;
                end else if (g == grp_mu && ok3 && v != 4'hF) begin
                    m_mu = cold3(v);  // mu always has one tap selected
                    exp  = reply_ack;
                end else if (g == grp_avk && ok4) begin
                    m_avk = cold4(v);
                    exp   = reply_ack;
                end else if (g == grp_fil1 && okf) begin
                    m_fil1 = (v == 4'h0);
                    exp    = reply_ack;
                end else if (g == grp_fil2 && okf) begin
                    m_fil2 = (v == 4'h0);
                    exp    = reply_ack;
                end
            end
            code_sel_spi: begin
                if (ok3) begin
                    m_cs = cold3(v);
                    exp  = reply_ack;
                end
            end
            code_read_out: begin
                case (v)
                    4'h1:    exp = {4'h0, m_input};
                    4'h2:    exp = {5'h00, m_mu};
                    4'h3:    exp = {4'h0, m_avk};
                    4'h4:    exp = {7'h00, m_fil1};
                    4'h5:    exp = {7'h00, m_fil2};
                    default: exp = 8'hFF;
                endcase
            end
            code_meas_state: exp = {4'h1, f};
            default:         has_reply = 1'b0;  // Dropped after the command byte
        endcase
    endtask

    task automatic run_transaction();
        int         kind;
        int         r;
        int         quiet;
        logic [7:0] c;
        logic [7:0] p;
        logic [7:0] exp;
        logic       has_reply;
        logic       seen;
        kind = $urandom_range(8, 0);
        r    = $urandom_range(255, 0);
        p    = r[7:0];
        if (kind <= 2) begin
            r = $urandom_range(6, 0);
            c = code_set_out;
            p = {r[3:0], pick_value()};
        end else if (kind <= 4) begin
            r = $urandom_range(6, 0);
            c = code_read_out;
            p = {4'h0, r[3:0]};
        end else if (kind <= 6) begin
            c = code_sel_spi;
            p = {4'h0, pick_value()};
        end else if (kind == 7) begin
            c = code_meas_state;
        end else begin
            do begin
                r = $urandom_range(255, 0);
            end while (r >= 1 && r <= 4);
            c = r[7:0];
        end

        @(negedge clk);
        r          = $urandom_range(255, 0);
        host_bytes = {c, p, r[7:0]};
        r          = $urandom_range(15, 0);
        fifo_level = r[3:0];
        load       = 1'b1;  // Two edges wide, the model may take it twice
        repeat (2) @(negedge clk);
        load    = 1'b0;
        spi_csn = 1'b0;

        while (!(rd_en || wr_en))
            @(negedge clk);
        quiet = 0;
        while (quiet < 10) begin  // Bus idle long after the last access
            @(negedge clk);
            if (rd_en || wr_en)
                quiet = 0;
            else
                quiet = quiet + 1;
        end
        check_value("cs_out", {5'h00, cs_out}, 8'h07);  // Forced off while selected

        spi_csn = 1'b1;
        repeat (5) @(negedge clk);
        predict(c, p, fifo_level, has_reply, exp);

        check_true(tx_count > 0 && tx_count <= 64, "transmit write count out of range");
        seen = 1'b0;
        for (int k = 0; k < tx_count; k++) begin
            if (!has_reply) begin
                check_value("tx_data", tx_log[k], 8'h00);
            end else if (seen || tx_log[k] != 8'h00) begin
                check_value("tx_data", tx_log[k], exp);  // Reloads repeat the reply
                seen = 1'b1;
            end
        end
        if (has_reply)
            check_value("reply", tx_log[tx_count - 1], exp);

        check_value("input_sel", {4'h0, input_sel}, {4'h0, m_input});
        check_value("mu_sel", {5'h00, mu_sel}, {5'h00, m_mu});
        check_value("avk_sel", {4'h0, avk_sel}, {4'h0, m_avk});
        check_value("fil1_sel", {7'h00, fil1_sel}, {7'h00, m_fil1});
        check_value("fil2_sel", {7'h00, fil2_sel}, {7'h00, m_fil2});
        check_value("cs_out", {5'h00, cs_out}, {5'h00, m_cs});
    endtask

    initial begin
        void'($urandom(32'hbaf7));
        rst_n      = 1'b1;
        spi_csn    = 1'b1;
        load       = 1'b0;
        host_bytes = 24'h0;
        fifo_level = 4'h0;
        m_input    = input_sel_rst;
        m_mu       = mu_sel_rst;
        m_avk      = avk_sel_rst;
        m_fil1     = fil1_rst;
        m_fil2     = fil2_rst;
        m_cs       = cs_rst;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        for (int i = 0; i < num_trans; i++)
            run_transaction();
        $display("test passed");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/spi_ctrl_pkg.sv
verilog/csn_sync.sv
verilog/efb_sequencer.sv
verilog/select_regs.sv
verilog/spi_ctrl_top.sv
tb/spi_ctrl_props.sv
tb/efb_spi_model.sv
tb/tb_spi_ctrl.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_spi_ctrl -o sim_spi_ctrl
./obj_dir/sim_spi_ctrl
